// ==== project.f ====
rtl/network_config.sv
rtl/source_config.sv
rtl/charge_if.sv
rtl/network_source.sv
rtl/neuron_array.sv
rtl/network_sink.sv
rtl/network_top.sv
testbench/network_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the spiking network subsystem
VERILATOR ?= verilator
TOP       ?= network_tb
LINT_TOP  ?= network_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/network_tb.sv ====
// self-checking testbench for network_top that applies a command table and checks results against a model
module network_tb;

    // same values as the DUT defaults
    localparam int THRESHOLD = 40;
    localparam int LEAK = 2;
    localparam int NIN = network_config::NET_NUM_INP;
    localparam int NOUT = network_config::NET_NUM_OUT;
    localparam int CW = network_config::NET_CHARGE_WIDTH;
    localparam int SRC_W = source_config::SRC_WIDTH;
    localparam int STEP_W = source_config::STEP_WIDTH;
    // signed potential range of the model
    localparam int POT_HI = (1 << (network_config::NET_POT_WIDTH - 1)) - 1;
    localparam int POT_LO = -(1 << (network_config::NET_POT_WIDTH - 1));
    // cycles that any single wait may take
    localparam int TIMEOUT = 200;
    localparam int N_TESTS = 5;
    localparam int N_STIM = 31;

    // each row holds test, opcode (0 NOM, 1 CLR), charge 0, charge 1, charge 2, charge 3
    // expected spikes come from the model and expected steps count up from 0
    localparam int STIM [N_STIM][6] = '{
        '{0, 0,    5,    5,    5,    5},
        '{1, 0,   10,   10,   10,   10},
        '{1, 0,   20,   -5,   15,    0},
        '{1, 0,   20,   -5,   15,    0},
        '{1, 0,  -30,   25,  -10,   40},
        '{1, 0,   12,    0,   12,   30},
        '{1, 0,    0,   60,  -60,    0},
        // bring neuron 0 just under the threshold
        '{2, 0,   10,   10,   10,    9},
        // small charges that leak away keep it there
        '{2, 0,    1,    0,    0,    1},
        '{2, 0,    1,    0,    0,    1},
        // drive neuron 0 into the negative bound
        '{2, 0, -128, -128, -128, -128},
        '{2, 0, -128, -128, -128, -128},
        '{2, 0, -128, -128, -128, -128},
        '{2, 0, -128, -128, -128, -128},
        '{2, 0, -128, -128, -128, -128},
        '{2, 0,  127,  127,  127,  127},
        // CLR charges are ignored
        '{3, 1,   50,   50,   50,   50},
        '{3, 0,    5,    5,    5,    5},
        '{3, 1,    0,    0,    0,    0},
        '{3, 1,    0,    0,    0,    0},
        '{3, 0,   10,   10,   10,   10},
        '{4, 0,   30,   30,    0,    0},
        '{4, 0,   15,  -20,   25,    5},
        '{4, 0,   40,    0,    0,   40},
        '{4, 1,    9,    9,    9,    9},
        '{4, 0,  -10,   50,   -5,   20},
        '{4, 0,   25,   25,   25,   25},
        '{4, 0,    7,   -7,   33,    1},
        '{4, 0,    0,    0,   45,    0},
        '{4, 0,   60,  -60,   60,  -60},
        '{4, 0,    3,    3,    3,    3}
    };

    // random out_ready per test
    localparam int TEST_BP [N_TESTS] = '{0, 0, 0, 0, 1};

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    logic [SRC_W-1:0] src;
    logic out_valid;
    logic [NOUT-1:0] out_spikes;
    logic [STEP_W-1:0] out_step;
    logic out_ready;

    logic bp_on;
    int err_cnt = 0;
    int chk_cnt = 0;
    bit timed_out = 1'b0;
    // model potentials and results still in flight
    int model_pot [NOUT] = '{default: 0};
    logic [NOUT-1:0] exp_q [$];
    logic [STEP_W-1:0] exp_step = '0;
    // last offered result while stalled
    bit stalled = 1'b0;
    logic [NOUT-1:0] held_spikes;
    logic [STEP_W-1:0] held_step;

    network_top #(
        .THRESHOLD (THRESHOLD),
        .LEAK      (LEAK)
    ) DUT (
        .clk        (clk),
        .arstn      (arstn),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src        (src),
        .out_valid  (out_valid),
        .out_spikes (out_spikes),
        .out_step   (out_step),
        .out_ready  (out_ready)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // the sink is always ready unless the test asks for back-pressure
    initial begin : drive_ready
        // fixed seed so the back-pressure pattern repeats from run to run
        void'($urandom(32'he2d6));
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= bp_on ? 1'($urandom) : 1'b1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    // one NOM step of the integrate-and-fire rule on the model potentials
    function automatic logic [NOUT-1:0] model_step(input int r);
        logic [NOUT-1:0] spikes;
        int p;
        spikes = '0;
        for (int j = 0; j < NOUT; j++) begin
            p = model_pot[j];
            // leak toward zero without passing it
            if (p > LEAK) begin
                p = p - LEAK;
            end else if (p < -LEAK) begin
                p = p + LEAK;
            end else begin
                p = 0;
            end
            for (int i = 0; i < NIN; i++) begin
                p = p + network_config::NET_WEIGHT[j][i] * STIM[r][2+i];
            end
            if (p > POT_HI) begin
                p = POT_HI;
            end else if (p < POT_LO) begin
                p = POT_LO;
            end
            // fire and reset
            if (p >= THRESHOLD) begin
                spikes[j] = 1'b1;
                p = 0;
            end
            model_pot[j] = p;
        end
        return spikes;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset and first step";
            1: return "integrate and fire";
            2: return "leak and saturation";
            3: return "clear";
            default: return "back-pressure";
        endcase
    endfunction

    // offer one table row and wait for the handshake
    task automatic send_cmd(input int r, output bit ok);
        logic [SRC_W-1:0] word;
        int cnt;
        // opcode on top with charge 0 in the highest charge field
        word[SRC_W-1] = STIM[r][1] != 0;
        for (int i = 0; i < NIN; i++) begin
            word[SRC_W-2-i*CW -: CW] = CW'(STIM[r][2+i]);
        end
        src_valid <= 1'b1;
        src <= word;
        cnt = 0;
        ok = 1'b0;
        while (!ok && cnt < TIMEOUT) begin
            @(posedge clk);
            ok = src_ready;
            cnt++;
        end
        if (!ok) begin
            $display("timeout, command %0d was not accepted within %0d cycles", r, TIMEOUT);
        end else if (STIM[r][1] != 0) begin
            foreach (model_pot[j]) begin
                model_pot[j] = 0;
            end
        end else begin
            exp_q.push_back(model_step(r));
        end
    endtask

    // wait until every expected result has left the DUT
    task automatic wait_drain(output bit ok);
        int cnt;
        cnt = 0;
        ok = 1'b0;
        // sampled on the falling edge away from queue and output updates
        while (!ok && cnt < TIMEOUT) begin
            @(negedge clk);
            ok = exp_q.size() == 0 && !out_valid;
            cnt++;
        end
        if (!ok) begin
            $display("timeout, %0d results still missing after %0d cycles",
                     exp_q.size(), TIMEOUT);
        end
        @(posedge clk);
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int sent;
        bit ok;
        errs_before = err_cnt;
        sent = 0;
        ok = 1'b1;
        bp_on <= TEST_BP[t] != 0;
        for (int r = 0; r < N_STIM; r++) begin
            if (ok && STIM[r][0] == t) begin
                send_cmd(r, ok);
                sent++;
            end
        end
        src_valid <= 1'b0;
        if (ok) begin
            wait_drain(ok);
        end
        if (!ok) begin
            timed_out = 1'b1;
        end
        $display("test %0d %s: %0d commands, %0d errors", t, test_name(t), sent,
                 err_cnt - errs_before);
    endtask

    // checks every result transfer and every stalled cycle
    always @(posedge clk) begin : monitor
        logic [NOUT-1:0] exp_spk;
        if (arstn) begin
            // a stalled result comes back unchanged
            if (stalled) begin
                check_val("out_valid", 32'(out_valid), 32'd1);
                check_val("out_spikes", 32'(out_spikes), 32'(held_spikes));
                check_val("out_step", 32'(out_step), 32'(held_step));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a result with step 0x%0h arrived but no step was outstanding",
                             out_step);
                    err_cnt++;
                end else begin
                    exp_spk = exp_q.pop_front();
                    check_val("out_spikes", 32'(out_spikes), 32'(exp_spk));
                    check_val("out_step", 32'(out_step), 32'(exp_step));
                    exp_step = exp_step + 1'b1;
                end
            end
            stalled = out_valid && !out_ready;
            held_spikes = out_spikes;
            held_step = out_step;
        end
    end

    initial begin : main
        arstn <= 1'b0;
        src_valid <= 1'b0;
        src <= '0;
        bp_on <= 1'b0;
        repeat (5) @(posedge clk);
        arstn <= 1'b1;
        @(posedge clk);
        // pipeline is empty and the source is ready
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("src_ready", 32'(src_ready), 32'd1);
        for (int t = 0; t < N_TESTS; t++) begin
            if (!timed_out) begin
                run_test(t);
            end
        end
        $display("results %0d, checks %0d, errors %0d, timeouts %0d", exp_step, chk_cnt,
                 err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/network_top.sv ====
// top level of the spiking inference subsystem, wires decode, execute and result stages together
module network_top #(
    // firing potential, passed to the neuron array
    parameter int THRESHOLD = 40,
    // leak per NOM step, passed to the neuron array
    parameter int LEAK = 2
) (
    input  logic clk,
    input  logic arstn,
    // command handshake and word
    input  logic src_valid,
    output logic src_ready,
    input  logic [source_config::SRC_WIDTH-1:0] src,
    // result handshake and payload
    output logic out_valid,
    output logic [network_config::NET_NUM_OUT-1:0] out_spikes,
    output logic [source_config::STEP_WIDTH-1:0] out_step,
    input  logic out_ready
);

    // decoded charges between source and array
    charge_if net_bus ();

    // spike path between array and sink
    logic spk_valid;
    logic spk_ready;
    logic [network_config::NET_NUM_OUT-1:0] spk;

    // decode, no latency
    network_source u_source (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src       (src),
        .net       (net_bus.source)
    );

    // integrate, leak and fire, one register stage
    neuron_array #(
        .THRESHOLD (THRESHOLD),
        .LEAK      (LEAK)
    ) u_array (
        .clk       (clk),
        .arstn     (arstn),
        .net       (net_bus.array),
        .spk_valid (spk_valid),
        .spk       (spk),
        .spk_ready (spk_ready)
    );

    // result register and step count, second register stage
    network_sink u_sink (
        .clk        (clk),
        .arstn      (arstn),
        .spk_valid  (spk_valid),
        .spk        (spk),
        .spk_ready  (spk_ready),
        .out_valid  (out_valid),
        .out_spikes (out_spikes),
        .out_step   (out_step),
        .out_ready  (out_ready)
    );

endmodule

// ==== rtl/network_sink.sv ====
// result stage, registers each spike vector with its step number and offers it on the output handshake
module network_sink (
    input  logic clk,
    input  logic arstn,
    // spike vector from the neuron array
    input  logic spk_valid,
    input  logic [network_config::NET_NUM_OUT-1:0] spk,
    output logic spk_ready,
    // result handshake
    output logic out_valid,
    output logic [network_config::NET_NUM_OUT-1:0] out_spikes,
    output logic [source_config::STEP_WIDTH-1:0] out_step,
    input  logic out_ready
);

    // number of results taken so far
    logic [source_config::STEP_WIDTH-1:0] step_cnt;

    // vector taken from the array this cycle
    logic accept;

    // free when empty or when the current result leaves this cycle
    assign spk_ready = !out_valid || out_ready;
    assign accept = spk_valid && spk_ready;

    // valid flag and step counter
    always_ff @(posedge clk) begin : upd_ctrl
        if (!arstn) begin
            out_valid <= 1'b0;
            step_cnt <= '0;
        end else begin
            if (accept) begin
                out_valid <= 1'b1;
                // one step per result, wraps silently
                step_cnt <= step_cnt + 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // result payload
    // out_step takes the count before the increment, so the first result is step 0
    always_ff @(posedge clk) begin : upd_out
        if (accept) begin
            out_spikes <= spk;
            out_step <= step_cnt;
        end
    end

    // an offered result stays offered until it is taken
    property p_out_hold;
        @(posedge clk) disable iff (!arstn)
        out_valid && !out_ready |=> out_valid;
    endproperty

    a_out_hold : assert property (p_out_hold)
        else $error("out_valid dropped before out_ready");

endmodule

// ==== rtl/neuron_array.sv ====
// execute stage, a fully connected layer of integrate-and-fire neurons with a one-entry spike register
module neuron_array #(
    // potential at or above which a neuron fires
    parameter int THRESHOLD = 40,
    // amount removed toward zero on every NOM step
    parameter int LEAK = 2
) (
    input  logic clk,
    input  logic arstn,
    // decoded charges from the source
    charge_if.array net,
    // spike vector towards the sink
    output logic spk_valid,
    output logic [network_config::NET_NUM_OUT-1:0] spk,
    input  logic spk_ready
);

    localparam int POT_W = network_config::NET_POT_WIDTH;
    // headroom for the leaked potential plus NET_NUM_INP full-scale charges
    localparam int SUM_W = POT_W + 2;

    // leak amount at potential width
    localparam logic signed [POT_W-1:0] LEAK_P = POT_W'(LEAK);
    // saturation bounds, sign extended to the sum width
    localparam logic signed [SUM_W-1:0] POT_MAX = SUM_W'((1 << (POT_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] POT_MIN = -SUM_W'(1 << (POT_W - 1));

    // membrane potentials
    logic signed [POT_W-1:0] pot [network_config::NET_NUM_OUT];

    // per neuron datapath
    logic signed [POT_W-1:0] leaked [network_config::NET_NUM_OUT];
    logic signed [SUM_W-1:0] total [network_config::NET_NUM_OUT];
    logic signed [POT_W-1:0] sat [network_config::NET_NUM_OUT];
    logic signed [POT_W-1:0] pot_next [network_config::NET_NUM_OUT];
    logic [network_config::NET_NUM_OUT-1:0] fire;

    // word taken from the source this cycle
    logic accept;

    // the spike register frees up when empty or drained in the same cycle
    assign net.net_ready = !spk_valid || spk_ready;
    assign accept = net.net_valid && net.net_ready;

    always_comb begin : calc_update
        for (int j = 0; j < network_config::NET_NUM_OUT; j++) begin
            // leak toward zero, never crossing it
            if (pot[j] > LEAK_P) begin
                leaked[j] = pot[j] - LEAK_P;
            end else if (pot[j] < -LEAK_P) begin
                leaked[j] = pot[j] + LEAK_P;
            end else begin
                leaked[j] = '0;
            end
            // weights are -1, 0 or +1, so add or subtract the charge
            total[j] = SUM_W'(leaked[j]);
            for (int i = 0; i < network_config::NET_NUM_INP; i++) begin
                case (network_config::NET_WEIGHT[j][i])
                    1:       total[j] = total[j] + SUM_W'(net.net_inp[i]);
                    -1:      total[j] = total[j] - SUM_W'(net.net_inp[i]);
                    default: total[j] = total[j];
                endcase
            end
            // clamp instead of wrapping
            if (total[j] > POT_MAX) begin
                sat[j] = POT_MAX[POT_W-1:0];
            end else if (total[j] < POT_MIN) begin
                sat[j] = POT_MIN[POT_W-1:0];
            end else begin
                sat[j] = total[j][POT_W-1:0];
            end
            // fire and reset the potential
            fire[j] = (sat[j] >= THRESHOLD);
            pot_next[j] = fire[j] ? '0 : sat[j];
        end
    end

    // potentials and the valid flag
    always_ff @(posedge clk) begin : upd_state
        if (!arstn) begin
            spk_valid <= 1'b0;
            for (int j = 0; j < network_config::NET_NUM_OUT; j++) begin
                pot[j] <= '0;
            end
        end else begin
            // CLR wipes every neuron at once
            if (accept) begin
                for (int j = 0; j < network_config::NET_NUM_OUT; j++) begin
                    pot[j] <= net.net_clear ? '0 : pot_next[j];
                end
            end
            // only a NOM makes a result
            if (accept && !net.net_clear) begin
                spk_valid <= 1'b1;
            end else if (spk_ready) begin
                spk_valid <= 1'b0;
            end
        end
    end

    // spike payload, loaded with each NOM step
    always_ff @(posedge clk) begin : upd_spk
        if (accept && !net.net_clear) begin
            spk <= fire;
        end
    end

    // a stalled result must not change under the sink
    a_spk_hold : assert property (
        @(posedge clk) disable iff (!arstn)
        spk_valid && !spk_ready |=> spk_valid && $stable(spk))
        else $error("spk changed while stalled");

    // a zero or negative threshold would fire every neuron on every step
    a_thr_pos : assert property (@(posedge clk) THRESHOLD > 0)
        else $error("THRESHOLD must be positive");

endmodule

// ==== rtl/network_source.sv ====
// decode stage, splits each command word into an opcode and signed charges with no added latency
module network_source (
    // clock and reset, only used by the input check
    input  logic clk,
    input  logic arstn,
    // command handshake
    input  logic src_valid,
    output logic src_ready,
    // command word
    input  logic [source_config::SRC_WIDTH-1:0] src,
    // decoded charges towards the neuron array
    charge_if.source net
);

    // opcode field of the current word
    source_config::opcode_t opcode;

    // valid goes forward and ready comes back, both without registers
    assign net.net_valid = src_valid;
    assign src_ready = net.net_ready;

    // top bit(s) hold the opcode
    assign opcode = source_config::opcode_t'(
        src[source_config::SRC_WIDTH-1 -: source_config::OPC_WIDTH]);

    // clear request is qualified by the handshake in the array
    assign net.net_clear = (opcode == source_config::CLR);

    // charge i starts right below the opcode, i fields down
    always_comb begin : calc_net_inp
        for (int i = 0; i < network_config::NET_NUM_INP; i++) begin
            net.net_inp[i] = src[source_config::SRC_WIDTH - source_config::OPC_WIDTH
                                 - i * network_config::NET_CHARGE_WIDTH - 1
                                 -: network_config::NET_CHARGE_WIDTH];
        end
    end

    // an unknown word would reach the potentials through the array
    // so the word must be clean whenever it is offered
    property p_src_known;
        @(posedge clk) disable iff (!arstn)
        src_valid |-> !$isunknown(src);
    endproperty

    a_src_known : assert property (p_src_known)
        else $error("src carries unknown bits while src_valid is high");

endmodule

// ==== rtl/charge_if.sv ====
// decoded charge bundle from network_source to neuron_array, with one modport per side
interface charge_if;

    // handshake, mirrors the source handshake
    logic net_valid;
    logic net_ready;

    // high when the current word is a CLR
    logic net_clear;

    // signed charges, index 0 comes from the highest charge field
    logic signed [network_config::NET_CHARGE_WIDTH-1:0] net_inp [network_config::NET_NUM_INP];

    // decode side
    modport source (
        output net_valid,
        output net_clear,
        output net_inp,
        input  net_ready
    );

    // execute side
    modport array (
        input  net_valid,
        input  net_clear,
        input  net_inp,
        output net_ready
    );

endinterface

// ==== rtl/source_config.sv ====
// command word and result formats for the source and sink stages, compiled after network_config
package source_config;

    // one-bit opcode in the top bit of each command word
    localparam int OPC_WIDTH = 1;

    // NOM carries one time step of charges
    // CLR zeroes all membrane potentials and makes no result
    typedef enum logic [OPC_WIDTH-1:0] {
        NOM = 1'b0,
        CLR = 1'b1
    } opcode_t;

    // command word: opcode on top, then charge 0 down to charge NET_NUM_INP-1
    // 1 + 4 * 8 = 33 bits with the default geometry
    localparam int SRC_WIDTH =
        OPC_WIDTH + network_config::NET_NUM_INP * network_config::NET_CHARGE_WIDTH;

    // result format
    // one spike bit per neuron plus a running step number
    // the step number wraps after 2**STEP_WIDTH results
    localparam int STEP_WIDTH = 16;

endpackage

// ==== rtl/network_config.sv ====
// network geometry, potential width and the fixed weight table, shared by the RTL and the testbench
package network_config;

    // inputs per command word, one charge each
    localparam int NET_NUM_INP = 4;

    // one integrate-and-fire neuron per output
    localparam int NET_NUM_OUT = 4;

    // signed input charge, two's complement
    localparam int NET_CHARGE_WIDTH = 8;

    // signed membrane potential
    // saturates at its signed bounds instead of wrapping
    localparam int NET_POT_WIDTH = 12;

    // weight per neuron (row) and input (column)
    // only -1, 0 and +1 are allowed, so the array needs no multipliers
    // fixed at build time, there is no weight loading
    localparam int NET_WEIGHT [NET_NUM_OUT][NET_NUM_INP] = '{
        // neuron 0 sums every input
        '{ 1,  1,  1,  1},
        // neuron 1 is inhibited by input 1
        '{ 1, -1,  1,  0},
        // neuron 2 is inhibited by input 2
        '{ 0,  1, -1,  1},
        // neuron 3 is inhibited by input 0
        '{-1,  0,  1,  1}
    };

endpackage
